// ==== cachePkg.sv ====
package cachePkg;

	////////////////////////////////////////
	// cache geometry
	////////////////////////////////////////

	// byte address of a 16-bit word
	parameter int AddrWidth = 16;
	parameter int DataWidth = 16;

	// 128 lines of 8 words each
	parameter int IndexBits = 7;
	parameter int WordBits = 3;

	// tag takes what is left above index and word, bit 0 is never used
	parameter int TagBits = AddrWidth - IndexBits - WordBits - 1;

	// cycles from a granted memory read to valid data
	parameter int ReadLatency = 4;

	////////////////////////////////////////
	// address and store entries
	////////////////////////////////////////

	// split of the 16-bit byte address
	typedef struct packed {
		logic [TagBits-1:0] tag;
		logic [IndexBits-1:0] index;
		logic [WordBits-1:0] word;
		// byte within the word, ignored
		logic byteSel;
	} addrT;

	// one tag store entry
	typedef struct packed {
		logic valid;
		logic [TagBits-1:0] tag;
	} tagEntryT;

	////////////////////////////////////////
	// pipeline and memory port
	////////////////////////////////////////

	// pipeline request, held while stall is high
	typedef struct packed {
		logic valid;
		logic write;
		addrT addr;
		logic [DataWidth-1:0] wdata;
	} cpuReqT;

	// one request per cycle into main memory
	typedef struct packed {
		logic en;
		logic wr;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] wdata;
	} memReqT;

	// read data coming back from main memory
	typedef struct packed {
		logic valid;
		logic [DataWidth-1:0] data;
	} memRspT;

endpackage

// ==== lineStore.sv ====
`timescale 1ns/1ps

module lineStore #(
	parameter type payloadT = logic [15:0],
	parameter int Depth = 128
) (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [$clog2(Depth)-1:0] waddr,
	input payloadT wdata,
	input logic [$clog2(Depth)-1:0] raddr,
	output payloadT rdata
);

	// one entry per line or per word, depending on the instance
	payloadT mem [Depth];

	// write on the clock edge
	// reset wipes every entry, this is what clears the tag valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// combinational read so a hit answers in the same cycle
	assign rdata = mem[raddr];

endmodule

// ==== refillEngine.sv ====
`timescale 1ns/1ps

module refillEngine #(
	parameter int WordBits = cachePkg::WordBits
) (
	input logic clk,
	input logic rst,
	input logic start,
	input cachePkg::addrT lineAddr,
	output cachePkg::memReqT refillReq,
	input cachePkg::memRspT rsp,
	output logic dataWe,
	output logic [WordBits-1:0] dataWord,
	output logic [cachePkg::DataWidth-1:0] dataOut,
	output logic tagWe,
	output logic busy
);
	import cachePkg::*;

	typedef enum logic {
		Idle,
		Busy
	} stateT;

	stateT state;

	// high while word reads are still going out
	logic issuing;
	// word of the next read to send
	logic [WordBits-1:0] issueCnt;
	// word the next returning response belongs to
	logic [WordBits-1:0] rspCnt;
	logic lastIssue;
	logic lastRsp;

	// line being refilled
	addrT lineReg;
	addrT issueAddr;

	assign lastIssue = &issueCnt;
	assign lastRsp = rsp.valid && (&rspCnt);

	////////////////////////////////////////
	// state and counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			issuing <= 1'b0;
			issueCnt <= '0;
			rspCnt <= '0;
		end else begin
			case (state)
				Idle: begin
					if (start) begin
						state <= Busy;
						issuing <= 1'b1;
						issueCnt <= '0;
						rspCnt <= '0;
					end
				end
				Busy: begin
					// reads go out back to back at one per cycle
					if (issuing) begin
						issueCnt <= issueCnt + 1'b1;
						if (lastIssue) begin
							issuing <= 1'b0;
						end
					end
					// responses may overlap with issuing
					if (rsp.valid) begin
						rspCnt <= rspCnt + 1'b1;
					end
					// tag is written on this same edge
					if (lastRsp) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// missing line taken from the request as the refill starts
	always_ff @(posedge clk) begin
		if (state == Idle && start) begin
			lineReg <= lineAddr;
		end
	end

	////////////////////////////////////////
	// memory reads and store writes
	////////////////////////////////////////

	always_comb begin
		issueAddr = lineReg;
		issueAddr.word = issueCnt;
		issueAddr.byteSel = 1'b0;
		refillReq.en = issuing;
		refillReq.wr = 1'b0;
		refillReq.addr = issueAddr;
		refillReq.wdata = '0;
	end

	assign busy = (state == Busy);

	// each returning word lands in its slot of the line
	assign dataWe = busy && rsp.valid;
	assign dataWord = rspCnt;
	assign dataOut = rsp.data;

	// valid tag goes in with the eighth word
	assign tagWe = busy && lastRsp;

endmodule

// ==== memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
	input cachePkg::memReqT refillReq,
	input cachePkg::memReqT writeReq,
	input cachePkg::memRspT memRsp,
	output cachePkg::memReqT memReq,
	output cachePkg::memRspT refillRsp
);

	logic refillGrant;
	logic writeGrant;

	// refill always wins
	assign refillGrant = refillReq.en;
	// write-through only gets the port when refill is quiet
	// stall keeps writes away during a refill anyway
	assign writeGrant = writeReq.en && !refillReq.en;

	////////////////////////////////////////
	// request mux
	////////////////////////////////////////

	always_comb begin
		if (refillGrant) begin
			memReq = refillReq;
		end else if (writeGrant) begin
			memReq = writeReq;
		end else begin
			// idle port, nothing enabled
			memReq = '0;
		end
	end

	// only refill reads produce responses
	assign refillRsp = memRsp;

endmodule

// ==== mainMemory.sv ====
`timescale 1ns/1ps

module mainMemory #(
	parameter int AddrWidth = cachePkg::AddrWidth,
	parameter int ReadLatency = cachePkg::ReadLatency
) (
	input logic clk,
	input logic rst,
	input cachePkg::memReqT memReq,
	output cachePkg::memRspT memRsp
);
	import cachePkg::*;

	// one entry per 16-bit word
	localparam int Words = 2 ** (AddrWidth - 1);

	logic [DataWidth-1:0] mem [Words];

	// read return pipeline, last stage is the response
	memRspT pipe [ReadLatency];

	logic [AddrWidth-2:0] wordAddr;
	logic rdEn;

	// drop the byte bit
	assign wordAddr = memReq.addr[AddrWidth-1:1];
	assign rdEn = memReq.en && !memReq.wr;

	// memory starts out all zero
	initial begin
		for (int i = 0; i < Words; i++) begin
			mem[i] = '0;
		end
	end

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	always @(posedge clk) begin
		if (memReq.en && memReq.wr) begin
			mem[wordAddr] <= memReq.wdata;
		end
	end

	////////////////////////////////////////
	// read pipeline
	////////////////////////////////////////

	// array read at grant time, data shows up ReadLatency cycles later
	// a new read can start every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ReadLatency; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0].valid <= rdEn;
			pipe[0].data <= rdEn ? mem[wordAddr] : '0;
			for (int i = 1; i < ReadLatency; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign memRsp = pipe[ReadLatency-1];

endmodule

// ==== cacheTop.sv ====
`timescale 1ns/1ps

module cacheTop #(
	parameter int IndexBits = cachePkg::IndexBits,
	parameter int WordBits = cachePkg::WordBits,
	parameter int ReadLatency = cachePkg::ReadLatency
) (
	input logic clk,
	input logic rst,
	input cachePkg::cpuReqT req,
	output logic [cachePkg::DataWidth-1:0] rdata,
	output logic stall
);
	import cachePkg::*;

	// hit check
	tagEntryT tagEntry;
	tagEntryT tagWdata;
	logic tagHit;
	logic readMiss;
	logic wrReq;
	logic writeHit;

	// refill side
	logic refillStart;
	logic refillBusy;
	logic refillDataWe;
	logic refillTagWe;
	logic [WordBits-1:0] refillWord;
	logic [DataWidth-1:0] refillData;

	// data store ports
	logic dataWe;
	logic [IndexBits+WordBits-1:0] dataWaddr;
	logic [IndexBits+WordBits-1:0] dataRaddr;
	logic [DataWidth-1:0] dataWdata;

	// memory side
	memReqT refillReq;
	memReqT writeReq;
	memReqT memReq;
	memRspT memRsp;
	memRspT refillRsp;

	////////////////////////////////////////
	// hit, miss and stall
	////////////////////////////////////////

	assign tagHit = tagEntry.valid && (tagEntry.tag == req.addr.tag);
	// only reads can miss since writes never allocate
	assign readMiss = req.valid && !req.write && !tagHit;
	// rises in the miss cycle itself and holds through the refill
	assign stall = readMiss || refillBusy;
	assign refillStart = readMiss && !refillBusy;

	// write-through of the current write finishes in one cycle
	assign wrReq = req.valid && req.write && !stall;
	assign writeHit = wrReq && tagHit;
	assign writeReq = '{en: wrReq, wr: wrReq, addr: req.addr, wdata: req.wdata};

	////////////////////////////////////////
	// stores
	////////////////////////////////////////

	// index comes from the held request and refill picks the word
	assign dataRaddr = {req.addr.index, req.addr.word};
	assign dataWe = refillDataWe || writeHit;
	assign dataWaddr = {req.addr.index, refillDataWe ? refillWord : req.addr.word};
	assign dataWdata = refillDataWe ? refillData : req.wdata;

	assign tagWdata = '{valid: 1'b1, tag: req.addr.tag};

	// one entry per word with the line index above the word index
	lineStore #(
		.payloadT(logic [DataWidth-1:0]),
		.Depth(2 ** (IndexBits + WordBits))
	) dataStore (
		.clk(clk),
		.rst(1'b0),
		.we(dataWe),
		.waddr(dataWaddr),
		.wdata(dataWdata),
		.raddr(dataRaddr),
		.rdata(rdata)
	);

	lineStore #(
		.payloadT(tagEntryT),
		.Depth(2 ** IndexBits)
	) tagStore (
		.clk(clk),
		.rst(rst),
		.we(refillTagWe),
		.waddr(req.addr.index),
		.wdata(tagWdata),
		.raddr(req.addr.index),
		.rdata(tagEntry)
	);

	////////////////////////////////////////
	// refill and memory
	////////////////////////////////////////

	refillEngine #(
		.WordBits(WordBits)
	) refill (
		.clk(clk),
		.rst(rst),
		.start(refillStart),
		.lineAddr(req.addr),
		.refillReq(refillReq),
		.rsp(refillRsp),
		.dataWe(refillDataWe),
		.dataWord(refillWord),
		.dataOut(refillData),
		.tagWe(refillTagWe),
		.busy(refillBusy)
	);

	memArbiter arbiter (
		.refillReq(refillReq),
		.writeReq(writeReq),
		.memRsp(memRsp),
		.memReq(memReq),
		.refillRsp(refillRsp)
	);

	mainMemory #(
		.AddrWidth(AddrWidth),
		.ReadLatency(ReadLatency)
	) memory (
		.clk(clk),
		.rst(rst),
		.memReq(memReq),
		.memRsp(memRsp)
	);

endmodule

// ==== cacheTb_chk.sv ====
`timescale 1ns/1ps

module cacheTb_chk #(
	parameter int ReadLatency = cachePkg::ReadLatency
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic busy,
	input cachePkg::memReqT memReq
);

	// longest legal stall, a full line refill
	localparam int MaxStall = 9 + ReadLatency;

	// number of assertion failures so far
	int assertFails = 0;

	////////////////////////////////////////
	// memory port and stall rules
	////////////////////////////////////////

	// refill owns the port, no write-through slips in
	noWriteInRefill: assert property (@(posedge clk) disable iff (rst) busy |-> !memReq.wr)
	else begin
		assertFails++;
		$error("memory write issued while the refill is busy");
	end

	// a refill always finishes
	stallBounded: assert property (@(posedge clk) disable iff (rst)
		$rose(stall) |-> ##[1:MaxStall] !stall)
	else begin
		assertFails++;
		$error("stall held longer than %0d cycles", MaxStall);
	end

	// nothing pending right after reset
	stallLowAfterReset: assert property (@(posedge clk) $fell(rst) |-> !stall)
	else begin
		assertFails++;
		$error("stall high in the first cycle after reset");
	end

endmodule

bind cacheTop cacheTb_chk #(
	.ReadLatency(ReadLatency)
) cacheChk (
	.clk(clk),
	.rst(rst),
	.stall(stall),
	.busy(refillBusy),
	.memReq(memReq)
);

// ==== cacheTb.sv ====
`timescale 1ns/1ps

module cacheTb;
	import cachePkg::*;

	localparam int MaxCases = 64;
	localparam int MissStall = 9 + ReadLatency;

	// one line of the case file
	typedef struct packed {
		logic [3:0] op;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
		logic [3:0] hit;
	} caseT;

	logic clk;
	logic rst;
	cpuReqT req;
	logic [DataWidth-1:0] rdata;
	logic stall;

	logic [$bits(caseT)-1:0] caseMem [MaxCases];
	caseT cur;
	cpuReqT nextReq;
	// every word written so far, keyed by word address
	logic [DataWidth-1:0] refMem [logic [AddrWidth-2:0]];
	int numCases;
	int stallCount;
	int cycleCount = 0;
	int cycleLimit = 50;

	cacheTop #(
		.IndexBits(IndexBits),
		.WordBits(WordBits),
		.ReadLatency(ReadLatency)
	) i_cacheTop (
		.clk(clk),
		.rst(rst),
		.req(req),
		.rdata(rdata),
		.stall(stall)
	);

	// 8 ns period
	always #4 clk = ~clk;

	////////////////////////////////////////
	// helpers and compare tasks
	////////////////////////////////////////

	task automatic stopRun();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	// last value written to the word, zero if never written
	function automatic logic [DataWidth-1:0] modelRead(input logic [AddrWidth-1:0] addr);
		if (refMem.exists(addr[AddrWidth-1:1])) begin
			return refMem[addr[AddrWidth-1:1]];
		end
		return '0;
	endfunction

	task automatic checkData(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp,
			input int n);
		if (got !== exp) begin
			$display("Error at %0t: case %0d read data %h, expected %h", $time, n, got, exp);
			stopRun();
		end
	endtask

	task automatic checkHit(input logic stallSeen, input logic expStall, input int n);
		if (stallSeen !== expStall) begin
			$display("Error at %0t: case %0d stall seen %0b, expected %0b", $time, n,
				stallSeen, expStall);
			stopRun();
		end
	endtask

	task automatic checkStallLen(input int got, input int exp, input int n);
		if (got != exp) begin
			$display("Error at %0t: case %0d stall lasted %0d cycles, expected %0d", $time, n,
				got, exp);
			stopRun();
		end
	endtask

	////////////////////////////////////////
	// watchdogs
	////////////////////////////////////////

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			stopRun();
		end
	end

	// the bound checker counts its own failures
	always @(negedge clk) begin
		if (i_cacheTop.cacheChk.assertFails != 0) begin
			$display("a bound assertion on the cache failed, see the error above");
			stopRun();
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		$readmemh("cacheCases.txt", caseMem);
		// count cases up to the end marker
		numCases = 0;
		cur = caseMem[0];
		while (numCases < MaxCases - 1 && (cur.op === 4'h0 || cur.op === 4'h1)) begin
			numCases++;
			cur = caseMem[numCases];
		end
		if (numCases == 0 || cur.op !== 4'hf) begin
			$display("cacheCases.txt is missing, empty or has a line with an unknown operation");
			stopRun();
		end
		cycleLimit = numCases * (10 + ReadLatency) + 50;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int n = 0; n < numCases; n++) begin
			cur = caseMem[n];
			nextReq.valid = 1'b1;
			nextReq.write = (cur.op == 4'h1);
			nextReq.addr = cur.addr;
			nextReq.wdata = (cur.op == 4'h1) ? cur.data : '0;
			// previous request completes on this edge, the next one goes out
			@(posedge clk);
			req <= nextReq;
			// mid-cycle sampling, count the cycles spent stalled
			stallCount = 0;
			@(negedge clk);
			while (stall === 1'b1) begin
				stallCount++;
				@(negedge clk);
			end
			if (cur.op == 4'h1) begin
				refMem[cur.addr[AddrWidth-1:1]] = cur.data;
			end else begin
				// the file itself must follow the memory rule
				if (modelRead(cur.addr) !== cur.data) begin
					$display("case %0d in cacheCases.txt expects %h but the model holds %h",
						n, cur.data, modelRead(cur.addr));
					stopRun();
				end
				checkData(rdata, cur.data, n);
			end
			checkHit(stallCount != 0, cur.hit == 4'h0, n);
			if (stallCount != 0) begin
				checkStallLen(stallCount, MissStall, n);
			end
		end

		@(posedge clk);
		req <= '0;
		@(posedge clk);
		if (i_cacheTop.cacheChk.assertFails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== cacheCases.txt ====
// columns op_addr_data_hit: op 0 read, 1 write, f ends the list; addr is a byte address
// data is write data or expected read data; hit 1 means no stall, writes never stall

// cold line at index 0, then a hit in the same line
0_0000_0000_0
0_0002_0000_1
// write hit updates cache and memory
1_0004_1234_1
0_0004_1234_1
// write miss, no allocate, then the read refills it
1_0120_beef_1
0_0120_beef_0
0_012e_0000_1
// fill memory first, then one refill brings the whole line
1_0340_0a0a_1
1_0342_0b0b_1
1_034e_0f0f_1
0_0342_0b0b_0
0_0340_0a0a_1
0_034e_0f0f_1
0_0344_0000_1
// same index with tag 1 replaces the line
1_0b40_5555_1
0_0b40_5555_0
0_0b42_0000_1
// back to tag 0 misses again, and tag 1 after it
0_0340_0a0a_0
0_0b40_5555_0
// odd byte address reads the same word
0_0b41_5555_1
1_0b4e_7777_1
0_0b4e_7777_1
// last index with the top tag
0_fff0_0000_0
1_fffe_a5a5_1
0_fffe_a5a5_1
// line 0 still holds tag 0
0_0004_1234_1
1_0804_9999_1
0_0004_1234_1
0_0804_9999_0
0_0004_1234_0
// end of list
f_0000_0000_0

// ==== all.f ====
cachePkg.sv
lineStore.sv
refillEngine.sv
memArbiter.sv
mainMemory.sv
cacheTop.sv
cacheTb_chk.sv
cacheTb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - cachePkg.sv
  - lineStore.sv
  - refillEngine.sv
  - memArbiter.sv
  - mainMemory.sv
  - cacheTop.sv
  - target: test
    files:
      - cacheTb_chk.sv
      - cacheTb.sv
